//--- src.f
src/axi_rd_pkg.sv
src/rd_map_pkg.sv
src/ar_slave_decoder.sv
src/ar_route_ctrl.sv
src/rd_outstanding_tracker.sv
src/rd_resp_merge.sv
src/rd_route_top.sv
bench/tb_rd_route.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_rd_route -f src.f --Mdir obj_dir -o sim_rd_route
./obj_dir/sim_rd_route | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
	echo "result: pass"
else
	echo "result: fail"
	exit 1
fi

//--- bench/tb_rd_route.sv
// Directed testbench for rd_route_top; the slave model answers in order with addr+beat data.
`timescale 1ns/1ps
`default_nettype none

module tb_rd_route;

	localparam int max_cycles = 4000;

	logic                   aclk = 1'b0;
	logic                   aresetn;
	axi_rd_pkg::ar_chan_t   us_ar;
	logic                   us_arvalid;
	logic                   us_arready;
	axi_rd_pkg::ar_chan_t   slv_ar;
	rd_map_pkg::slave_sel_t slv_arvalid;
	rd_map_pkg::slave_sel_t slv_arready = '0;
	axi_rd_pkg::r_chan_t    slv_r = '0;
	logic                   slv_rvalid = 1'b0;
	logic                   slv_rready;
	axi_rd_pkg::r_chan_t    us_r;
	logic                   us_rvalid;
	logic                   us_rready = 1'b0;

	axi_rd_pkg::ar_chan_t   acc_q [$]; // requests the slaves took.
	rd_map_pkg::slave_sel_t sel_q [$];
	axi_rd_pkg::ar_chan_t   rd_q [$];  // slave reads still owing beats.
	axi_rd_pkg::r_chan_t    got_q [$];
	logic                   ar_hold = 1'b0;
	logic                   ar_rand = 1'b0; // random stalls on arready and rready.
	int                     r_allow = 32'h7fff_ffff; // total slave beats allowed.
	int                     r_taken = 0;
	int                     r_beat = 0;
	int                     errors = 0;
	int                     cycles = 0;
	logic [31:0]            lfsr_tb = 32'hdfdd6fdf;
	logic [31:0]            lfsr_slv = 32'hdfdd6fdf;

	rd_route_top #(
		.max_outstanding (4)
	) rd_route_top_i (.*);

	always #20 aclk = ~aclk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32,22,2,1.
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_tb = lfsr_step(lfsr_tb);
			v = {v[30:0], lfsr_tb[0]};
		end
		return v;
	endfunction

	always @(posedge aclk) begin : slave_model
		rd_map_pkg::slave_sel_t rdy;
		logic                   rrdy;
		rdy  = '1;
		rrdy = 1'b1;
		if (|(slv_arvalid & slv_arready)) begin
			acc_q.push_back(slv_ar);
			sel_q.push_back(slv_arvalid & slv_arready);
			rd_q.push_back(slv_ar);
		end
		if (slv_rvalid && slv_rready) begin
			r_taken++;
			if (slv_r.last) begin
				void'(rd_q.pop_front());
				r_beat = 0;
			end else begin
				r_beat++;
			end
		end
		if (us_rvalid && us_rready) begin
			got_q.push_back(us_r);
		end
		if (rd_q.size() > 0 && r_taken < r_allow) begin
			slv_rvalid <= 1'b1;
			slv_r.id   <= rd_q[0].id;
			slv_r.data <= rd_q[0].addr + axi_rd_pkg::data_t'(r_beat);
			slv_r.resp <= axi_rd_pkg::resp_okay;
			slv_r.last <= r_beat == int'(rd_q[0].len);
		end else begin
			slv_rvalid <= 1'b0;
		end
		if (ar_rand) begin
			for (int i = 0; i < 3; i++) begin
				lfsr_slv = lfsr_step(lfsr_slv);
				rdy[i] = lfsr_slv[0];
			end
			lfsr_slv = lfsr_step(lfsr_slv);
			rrdy = lfsr_slv[0];
		end
		slv_arready <= ar_hold ? '0 : rdy;
		us_rready   <= rrdy;
	end

	always @(posedge aclk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("Timeout: the tests did not finish within %0d cycles", max_cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic flag_failure(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic check_ar(input string name, input axi_rd_pkg::ar_chan_t exp,
			input axi_rd_pkg::ar_chan_t act);
		if (act !== exp) begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_sel(input string name, input rd_map_pkg::slave_sel_t exp,
			input rd_map_pkg::slave_sel_t act);
		if (act !== exp) begin
			errors++;
			$display("Error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_r(input string name, input axi_rd_pkg::r_chan_t exp,
			input axi_rd_pkg::r_chan_t act);
		if (act !== exp) begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	function automatic axi_rd_pkg::ar_chan_t make_ar(input axi_rd_pkg::addr_t addr,
			input axi_rd_pkg::len_t len, input logic lock);
		axi_rd_pkg::ar_chan_t ar;
		ar       = '0;
		ar.addr  = addr;
		ar.len   = len;
		ar.size  = 3'd2; // 4-byte beats.
		ar.burst = 2'b01;
		ar.lock  = lock;
		ar.id    = axi_rd_pkg::id_t'(rand_bits(4));
		return ar;
	endfunction

	task automatic send_ar(input axi_rd_pkg::ar_chan_t ar);
		@(posedge aclk);
		us_ar      <= ar;
		us_arvalid <= 1'b1;
		@(negedge aclk);
		while (!us_arready) @(negedge aclk);
		@(posedge aclk);
		us_arvalid <= 1'b0;
	endtask

	task automatic check_accept(input string name, input axi_rd_pkg::ar_chan_t exp,
			input rd_map_pkg::slave_sel_t exp_sel);
		axi_rd_pkg::ar_chan_t   ar;
		rd_map_pkg::slave_sel_t sel;
		while (acc_q.size() == 0) @(negedge aclk);
		ar  = acc_q.pop_front();
		sel = sel_q.pop_front();
		check_ar(name, exp, ar);
		check_sel(name, exp_sel, sel);
	endtask

	// one upstream beat per len+1; decode errors carry zero data.
	task automatic expect_beats(input string name, input axi_rd_pkg::ar_chan_t ar,
			input logic dec);
		axi_rd_pkg::r_chan_t exp;
		axi_rd_pkg::r_chan_t got;
		for (int i = 0; i <= int'(ar.len); i++) begin
			while (got_q.size() == 0) @(negedge aclk);
			got      = got_q.pop_front();
			exp.id   = ar.id;
			exp.data = dec ? '0 : ar.addr + axi_rd_pkg::data_t'(i);
			exp.resp = dec ? axi_rd_pkg::resp_decerr : axi_rd_pkg::resp_okay;
			exp.last = i == int'(ar.len);
			check_r(name, exp, got);
		end
	endtask

	task automatic route_one(input string name, input axi_rd_pkg::addr_t addr,
			input rd_map_pkg::slave_sel_t exp_sel);
		axi_rd_pkg::ar_chan_t ar;
		ar = make_ar(addr, axi_rd_pkg::len_t'(rand_bits(2)), 1'b0);
		send_ar(ar);
		check_accept(name, ar, exp_sel);
		expect_beats(name, ar, 1'b0);
	endtask

	task automatic test_routing();
		axi_rd_pkg::addr_t nib;
		@(posedge aclk);
		ar_rand <= 1'b1;
		for (int k = 0; k < 3; k++) begin
			route_one("routing slave 0", rand_bits(28), 3'b001);
			route_one("routing slave 1", 32'h1000_0000 | rand_bits(24), 3'b010);
			nib = rand_bits(4);
			if (nib == '0) begin
				nib = 32'h1; // 0x10 belongs to slave 1.
			end
			route_one("routing slave 2", 32'h1000_0000 | (nib << 24) | rand_bits(24), 3'b100);
		end
	endtask

	task automatic test_priority();
		route_one("priority low edge", 32'h1000_0000, 3'b010);
		route_one("priority high edge", 32'h10FF_FFFF, 3'b010);
		route_one("priority inside", 32'h1000_0000 | rand_bits(24), 3'b010);
	endtask

	task automatic test_decerr();
		axi_rd_pkg::ar_chan_t ar;
		axi_rd_pkg::addr_t    top;
		for (int k = 0; k < 4; k++) begin
			top = rand_bits(4);
			if (top < 2) begin
				top = top + 2;
			end
			ar = make_ar((top << 28) | rand_bits(28), axi_rd_pkg::len_t'(rand_bits(3)), 1'b0);
			send_ar(ar);
			expect_beats("decode error", ar, 1'b1);
			check_sel("decode error arvalid", '0, slv_arvalid);
			if (acc_q.size() != 0) begin
				flag_failure("a decode-error read reached a slave");
			end
		end
	endtask

	task automatic test_backpressure();
		axi_rd_pkg::ar_chan_t a;
		axi_rd_pkg::ar_chan_t b;
		@(posedge aclk);
		ar_rand <= 1'b0;
		ar_hold <= 1'b1;
		a = make_ar(rand_bits(28), 8'd1, 1'b0);
		b = make_ar(32'h1000_0000 | rand_bits(24), 8'd2, 1'b0);
		send_ar(a);
		send_ar(b); // lands in the slot.
		repeat (6) begin
			@(negedge aclk);
			check_sel("backpressure arvalid", 3'b001, slv_arvalid);
			check_ar("backpressure payload", a, slv_ar);
			if (us_arready) begin
				flag_failure("us_arready high while a request waits in the slot");
			end
		end
		@(posedge aclk);
		ar_hold <= 1'b0;
		check_accept("backpressure first", a, 3'b001);
		check_accept("backpressure second", b, 3'b010);
		expect_beats("backpressure first", a, 1'b0);
		expect_beats("backpressure second", b, 1'b0);
	endtask

	task automatic test_outstanding();
		axi_rd_pkg::ar_chan_t reqs [0:4];
		@(posedge aclk);
		r_allow <= r_taken;
		for (int k = 0; k < 5; k++) begin
			reqs[k] = make_ar(rand_bits(28), 8'd0, 1'b0);
			send_ar(reqs[k]);
		end
		repeat (10) @(negedge aclk);
		if (acc_q.size() != 4) begin
			flag_failure($sformatf("expected 4 reads at the slaves, saw %0d", acc_q.size()));
		end
		check_sel("outstanding fifth held", '0, slv_arvalid);
		@(posedge aclk);
		r_allow <= r_taken + 1;
		repeat (12) @(negedge aclk);
		if (acc_q.size() != 5) begin
			flag_failure($sformatf("expected 5 reads after one return, saw %0d", acc_q.size()));
		end
		@(posedge aclk);
		r_allow <= 32'h7fff_ffff;
		for (int k = 0; k < 5; k++) begin
			check_accept("outstanding", reqs[k], 3'b001);
			expect_beats("outstanding", reqs[k], 1'b0);
		end
	endtask

	task automatic test_lock();
		axi_rd_pkg::ar_chan_t a;
		axi_rd_pkg::ar_chan_t b;
		axi_rd_pkg::ar_chan_t l;
		axi_rd_pkg::ar_chan_t f;
		@(posedge aclk);
		r_allow <= r_taken;
		a = make_ar(rand_bits(28), 8'd3, 1'b0);
		b = make_ar(rand_bits(28), 8'd3, 1'b0);
		l = make_ar(32'h1000_0000 | rand_bits(24), 8'd2, 1'b1);
		f = make_ar(32'h1800_0000 | rand_bits(24), 8'd1, 1'b0);
		send_ar(a);
		send_ar(b);
		send_ar(l);
		repeat (10) @(negedge aclk);
		if (acc_q.size() != 2) begin
			flag_failure("locked read issued while reads were outstanding");
		end
		@(posedge aclk);
		r_allow <= r_taken + 8; // beats of a and b only.
		check_accept("lock first", a, 3'b001);
		check_accept("lock second", b, 3'b001);
		expect_beats("lock first", a, 1'b0);
		expect_beats("lock second", b, 1'b0);
		if (acc_q.size() != 0) begin
			flag_failure("locked read issued before the last outstanding beat");
		end
		check_accept("lock locked", l, 3'b010);
		send_ar(f);
		repeat (10) @(negedge aclk);
		if (acc_q.size() != 0) begin
			flag_failure("read issued while the lock was held");
		end
		@(posedge aclk);
		r_allow <= 32'h7fff_ffff;
		expect_beats("lock locked", l, 1'b0);
		if (acc_q.size() != 0) begin
			flag_failure("read issued before the locked read's last beat");
		end
		check_accept("lock follower", f, 3'b100);
		expect_beats("lock follower", f, 1'b0);
	endtask

	initial begin
		us_ar      = '0;
		us_arvalid = 1'b0;
		aresetn    = 1'b0;
		repeat (10) @(posedge aclk);
		aresetn <= 1'b1;
		test_routing();
		test_priority();
		test_decerr();
		test_backpressure();
		test_outstanding();
		test_lock();
		repeat (5) @(posedge aclk);
		$display("tests done: %0d errors", errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src/rd_route_top.sv
// Read-address routing for one upstream port; responses must return in issue order.
`timescale 1ns/1ps
`default_nettype none

module rd_route_top #(
	parameter int max_outstanding = 4
) (
	input  wire                          aclk,
	input  wire                          aresetn,
	input  wire axi_rd_pkg::ar_chan_t    us_ar,
	input  wire                          us_arvalid,
	output logic                         us_arready,
	output axi_rd_pkg::ar_chan_t         slv_ar,
	output rd_map_pkg::slave_sel_t       slv_arvalid,
	input  wire rd_map_pkg::slave_sel_t  slv_arready,
	input  wire axi_rd_pkg::r_chan_t     slv_r,
	input  wire                          slv_rvalid,
	output logic                         slv_rready,
	output axi_rd_pkg::r_chan_t          us_r,
	output logic                         us_rvalid,
	input  wire                          us_rready
);

	logic                 trk_ready;
	logic                 trk_idle;
	logic                 issue_slave;
	logic                 decerr_start;
	axi_rd_pkg::ar_chan_t decerr_ar;
	logic                 decerr_busy;
	logic                 rvalid_inflight;
	logic                 rlast_done;
	axi_rd_pkg::id_t      rlast_id;

	ar_route_ctrl ar_route_ctrl_i (
		.aclk            (aclk),
		.aresetn         (aresetn),
		.us_ar           (us_ar),
		.us_arvalid      (us_arvalid),
		.us_arready      (us_arready),
		.slv_ar          (slv_ar),
		.slv_arvalid     (slv_arvalid),
		.slv_arready     (slv_arready),
		.trk_ready       (trk_ready),
		.trk_idle        (trk_idle),
		.issue_slave     (issue_slave),
		.decerr_start    (decerr_start),
		.decerr_ar       (decerr_ar),
		.decerr_busy     (decerr_busy),
		.rvalid_inflight (rvalid_inflight),
		.rlast_done      (rlast_done),
		.rlast_id        (rlast_id)
	);

	rd_outstanding_tracker #(
		.max_outstanding (max_outstanding)
	) rd_outstanding_tracker_i (
		.aclk        (aclk),
		.aresetn     (aresetn),
		.issue_slave (issue_slave),
		.rlast_done  (rlast_done),
		.ready       (trk_ready),
		.idle        (trk_idle)
	);

	rd_resp_merge rd_resp_merge_i (
		.aclk            (aclk),
		.aresetn         (aresetn),
		.decerr_start    (decerr_start),
		.decerr_ar       (decerr_ar),
		.decerr_busy     (decerr_busy),
		.slv_r           (slv_r),
		.slv_rvalid      (slv_rvalid),
		.slv_rready      (slv_rready),
		.us_r            (us_r),
		.us_rvalid       (us_rvalid),
		.us_rready       (us_rready),
		.rlast_done      (rlast_done),
		.rlast_id        (rlast_id),
		.rvalid_inflight (rvalid_inflight)
	);

endmodule

`default_nettype wire

//--- src/rd_resp_merge.sv
// R channel merge; slave beats pass through in order, decerr beats only while no slave read is open.
`timescale 1ns/1ps
`default_nettype none

module rd_resp_merge (
	input  wire                        aclk,
	input  wire                        aresetn,
	input  wire                        decerr_start,
	input  wire axi_rd_pkg::ar_chan_t  decerr_ar,
	output logic                       decerr_busy,
	input  wire axi_rd_pkg::r_chan_t   slv_r,
	input  wire                        slv_rvalid,
	output logic                       slv_rready,
	output axi_rd_pkg::r_chan_t        us_r,
	output logic                       us_rvalid,
	input  wire                        us_rready,
	output logic                       rlast_done,
	output axi_rd_pkg::id_t            rlast_id,
	output logic                       rvalid_inflight
);

	typedef enum logic {
		st_forward,
		st_decerr
	} state_t;

	state_t           state;
	axi_rd_pkg::len_t beats_left;
	axi_rd_pkg::id_t  dec_id;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state <= st_forward;
		end else if (state == st_forward && decerr_start) begin
			state <= st_decerr;
		end else if (state == st_decerr && us_rready && beats_left == '0) begin
			state <= st_forward;
		end
	end

	always_ff @(posedge aclk) begin
		if (decerr_start) begin
			beats_left <= decerr_ar.len;
			dec_id     <= decerr_ar.id;
		end else if (state == st_decerr && us_rready) begin
			beats_left <= beats_left - 1'b1;
		end
	end

	always_comb begin
		if (state == st_decerr) begin
			us_r.id   = dec_id;
			us_r.data = '0;
			us_r.resp = axi_rd_pkg::resp_decerr;
			us_r.last = beats_left == '0;
			us_rvalid = 1'b1;
		end else begin
			us_r      = slv_r;
			us_rvalid = slv_rvalid;
		end
	end

	assign slv_rready      = (state == st_forward) & us_rready;
	assign decerr_busy     = state == st_decerr;
	assign rlast_done      = us_rvalid & us_rready & us_r.last;
	assign rlast_id        = us_r.id;
	assign rvalid_inflight = us_rvalid;

endmodule

`default_nettype wire

//--- src/rd_outstanding_tracker.sv
// Outstanding slave read counter; max_outstanding must stay at or below 15.
`timescale 1ns/1ps
`default_nettype none

module rd_outstanding_tracker #(
	parameter int max_outstanding = 4
) (
	input  wire  aclk,
	input  wire  aresetn,
	input  wire  issue_slave,
	input  wire  rlast_done,
	output logic ready,
	output logic idle
);

	rd_map_pkg::outst_cnt_t cnt;
	logic                   dec;

	// decerr last beats arrive only at zero count and are ignored here.
	assign dec = rlast_done & (cnt != '0);

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			cnt <= '0;
		end else begin
			case ({issue_slave, dec})
				2'b10:   cnt <= cnt + 1'b1;
				2'b01:   cnt <= cnt - 1'b1;
				default: cnt <= cnt; // both or neither.
			endcase
		end
	end

	assign ready = cnt < rd_map_pkg::outst_cnt_t'(max_outstanding);
	assign idle  = cnt == '0;

endmodule

`default_nettype wire

//--- src/ar_route_ctrl.sv
// AR issue control; one hold slot, in-order only, lock blocks all issue until its last beat.
`timescale 1ns/1ps
`default_nettype none

module ar_route_ctrl (
	input  wire                          aclk,
	input  wire                          aresetn,
	input  wire axi_rd_pkg::ar_chan_t    us_ar,
	input  wire                          us_arvalid,
	output logic                         us_arready,
	output axi_rd_pkg::ar_chan_t         slv_ar,
	output rd_map_pkg::slave_sel_t       slv_arvalid,
	input  wire rd_map_pkg::slave_sel_t  slv_arready,
	input  wire                          trk_ready,
	input  wire                          trk_idle,
	output logic                         issue_slave,
	output logic                         decerr_start,
	output axi_rd_pkg::ar_chan_t         decerr_ar,
	input  wire                          decerr_busy,
	input  wire                          rvalid_inflight,
	input  wire                          rlast_done,
	input  wire axi_rd_pkg::id_t         rlast_id
);

	logic                   slot_full;
	axi_rd_pkg::ar_chan_t   slot_ar;
	axi_rd_pkg::ar_chan_t   cand_ar;
	logic                   cand_valid;
	rd_map_pkg::slave_sel_t sel;
	logic                   miss;
	logic                   ar_pending;
	logic                   trk_ok;
	logic                   lock_ok;
	logic                   can_issue;
	logic                   issue;
	logic                   lock_held;
	axi_rd_pkg::id_t        lock_id;

	// held entry has priority over the upstream port.
	assign cand_ar    = slot_full ? slot_ar : us_ar;
	assign cand_valid = slot_full | us_arvalid;
	assign us_arready = ~slot_full;

	ar_slave_decoder ar_slave_decoder_i (
		.addr (cand_ar.addr),
		.sel  (sel),
		.miss (miss)
	);

	assign ar_pending = |(slv_arvalid & ~slv_arready);
	assign trk_ok     = miss ? trk_idle : trk_ready; // misses go out only when idle.
	assign lock_ok    = ~cand_ar.lock | (trk_idle & ~rvalid_inflight);
	assign can_issue  = ~ar_pending & ~decerr_busy & trk_ok & ~lock_held & lock_ok;
	assign issue      = cand_valid & can_issue;

	assign issue_slave  = issue & ~miss;
	assign decerr_start = issue & miss;
	assign decerr_ar    = cand_ar;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			slot_full <= 1'b0;
		end else begin
			slot_full <= cand_valid & ~can_issue;
		end
	end

	// capture only from upstream; a held entry stays put.
	always_ff @(posedge aclk) begin
		if (us_arvalid && !slot_full && !can_issue) begin
			slot_ar <= us_ar;
		end
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			slv_arvalid <= '0;
		end else if (issue) begin
			slv_arvalid <= sel; // zero on a miss.
		end else begin
			slv_arvalid <= slv_arvalid & ~slv_arready;
		end
	end

	always_ff @(posedge aclk) begin
		if (issue_slave) begin
			slv_ar <= cand_ar;
		end
	end

	// the locked read may itself be a miss; its decerr last beat releases it.
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			lock_held <= 1'b0;
			lock_id   <= '0;
		end else if (issue && cand_ar.lock) begin
			lock_held <= 1'b1;
			lock_id   <= cand_ar.id;
		end else if (rlast_done && rlast_id == lock_id) begin
			lock_held <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- src/ar_slave_decoder.sv
// Combinational priority decode against the fixed map; sel is one-hot or zero on a miss.
`timescale 1ns/1ps
`default_nettype none

module ar_slave_decoder (
	input  wire axi_rd_pkg::addr_t     addr,
	output rd_map_pkg::slave_sel_t     sel,
	output logic                       miss
);

	rd_map_pkg::slave_sel_t hit;

	always_comb begin
		for (int n = 0; n < rd_map_pkg::num_slaves; n++) begin
			hit[n] = (addr & rd_map_pkg::slave_mask[n]) == rd_map_pkg::slave_base[n];
		end
	end

	// lowest index wins.
	always_comb begin
		sel = '0;
		for (int n = 0; n < rd_map_pkg::num_slaves; n++) begin
			if (hit[n] && sel == '0) begin
				sel[n] = 1'b1;
			end
		end
	end

	assign miss = ~|hit;

endmodule

`default_nettype wire

//--- src/rd_map_pkg.sv
// Fixed three-slave address map; overlapping entries resolve to the lowest index.
`default_nettype none

package rd_map_pkg;

	localparam int num_slaves = 3;

	typedef logic [num_slaves-1:0] slave_sel_t; // one-hot, bit n is slave n.

	// slave 1 sits inside slave 2's region and wins by priority.
	localparam axi_rd_pkg::addr_t slave_base [0:num_slaves-1] = '{
		32'h0000_0000,
		32'h1000_0000,
		32'h1000_0000
	};

	localparam axi_rd_pkg::addr_t slave_mask [0:num_slaves-1] = '{
		32'hF000_0000,
		32'hFF00_0000,
		32'hF000_0000
	};

	typedef logic [3:0] outst_cnt_t; // max_outstanding up to 15.

endpackage

`default_nettype wire

//--- src/axi_rd_pkg.sv
// AXI read channel types; single read port, 32-bit data, no user or region signals.
`default_nettype none

package axi_rd_pkg;

	typedef logic [31:0] addr_t; // byte address.
	typedef logic [3:0]  id_t;
	typedef logic [7:0]  len_t;  // beats minus one.
	typedef logic [31:0] data_t;
	typedef logic [1:0]  resp_t;

	localparam resp_t resp_okay   = 2'b00;
	localparam resp_t resp_decerr = 2'b11;

	typedef struct packed {
		addr_t      addr;
		len_t       len;
		logic [2:0] size;
		logic [1:0] burst;
		logic       lock;
		logic [3:0] cache;
		logic [2:0] prot;
		id_t        id;
	} ar_chan_t; // 57 bits.

	typedef struct packed {
		id_t   id;
		data_t data;
		resp_t resp;
		logic  last;
	} r_chan_t; // 39 bits.

endpackage

`default_nettype wire
